// File: hdl/pixel_pkg.sv
`default_nettype none

package pixel_pkg;

  localparam int unsigned PIXEL_W = 8;

  // Frame size in pixels.
  localparam int unsigned IMG_COLS = 16;
  localparam int unsigned IMG_ROWS = 12;

  localparam int unsigned COL_W = $clog2(IMG_COLS);
  localparam int unsigned ROW_W = $clog2(IMG_ROWS);

  localparam int unsigned WIN_PIXELS = 9;
  localparam int unsigned CENTER_POS = 4; // Middle of the 3x3 window.

  // Nine full-scale pixels add up to 2295.
  localparam int unsigned WIN_SUM_W = 12;

  typedef logic [PIXEL_W-1:0] pixel_t;

  // Row-major 3x3 neighborhood, p0 top-left.
  typedef struct packed {
    pixel_t p0;
    pixel_t p1;
    pixel_t p2;
    pixel_t p3;
    pixel_t p4;
    pixel_t p5;
    pixel_t p6;
    pixel_t p7;
    pixel_t p8;
  } window_t;

endpackage

`default_nettype wire

// File: hdl/lbp_pkg.sv
`default_nettype none

package lbp_pkg;

  localparam int unsigned NUM_NEIGHBORS = 8;
  localparam int unsigned CODE_W = NUM_NEIGHBORS;
  localparam int unsigned LABEL_W = 4;

  // Window position behind each code bit.
  // Bit 0 is east, then NE, N, NW, W, SW, S, SE going counter-clockwise.
  localparam int unsigned NBR_POS [NUM_NEIGHBORS] = '{5, 2, 1, 0, 3, 6, 7, 8};

  // Uniform patterns have at most this many circular transitions.
  localparam int unsigned MAX_UNIFORM_TRANS = 2;

  typedef logic [CODE_W-1:0] code_t;
  typedef logic [LABEL_W-1:0] label_t;

  localparam label_t NONUNIFORM_LABEL = 4'd9;

  typedef struct packed {
    code_t sign; // Neighbor against center.
    code_t ni;   // Neighbor against window mean.
  } codes_t;

  typedef struct packed {
    label_t sign;
    label_t ni;
  } result_t;

endpackage

`default_nettype wire

// File: hdl/window_builder.sv
`timescale 1ns/100ps
`default_nettype none

module window_builder (
  input  wire logic              clk,
  input  wire logic              rst_i,
  input  wire logic              advance_i,
  input  wire logic              pix_valid_i,
  input  wire pixel_pkg::pixel_t pix_i,
  output pixel_pkg::window_t     win_o,
  output logic                   win_valid_o
);

  import pixel_pkg::*;

  pixel_t line1 [IMG_COLS]; // Previous row.
  pixel_t line2 [IMG_COLS]; // Two rows back.

  logic [COL_W-1:0] col_q;
  logic [ROW_W-1:0] row_q;

  logic   accept;
  logic   col_last;
  logic   row_last;
  logic   interior;
  pixel_t top_pix;
  pixel_t mid_pix;

  assign accept   = advance_i & pix_valid_i;
  assign col_last = col_q == COL_W'(IMG_COLS - 1);
  assign row_last = row_q == ROW_W'(IMG_ROWS - 1);

  // Center lands one row up and one column left.
  assign interior = (col_q >= COL_W'(2)) && (row_q >= ROW_W'(2));

  // Same column from the two rows above.
  assign top_pix = line2[col_q];
  assign mid_pix = line1[col_q];

  // Raster position of the next pixel.
  always_ff @(posedge clk) begin
    if (rst_i) begin
      col_q <= '0;
      row_q <= '0;
    end else if (accept) begin
      if (col_last) begin
        col_q <= '0;
        row_q <= row_last ? '0 : row_q + 1'b1; // Wrap at frame end.
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  // Each accepted pixel pushes its column down by one row.
  always_ff @(posedge clk) begin
    if (accept) begin
      line2[col_q] <= mid_pix;
      line1[col_q] <= pix_i;
    end
  end

  // Window slides left, the new column enters on the right.
  always_ff @(posedge clk) begin
    if (accept) begin
      win_o.p0 <= win_o.p1;
      win_o.p1 <= win_o.p2;
      win_o.p2 <= top_pix;
      win_o.p3 <= win_o.p4;
      win_o.p4 <= win_o.p5;
      win_o.p5 <= mid_pix;
      win_o.p6 <= win_o.p7;
      win_o.p7 <= win_o.p8;
      win_o.p8 <= pix_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      win_valid_o <= 1'b0;
    end else if (advance_i) begin
      win_valid_o <= accept & interior;
    end
  end

endmodule

`default_nettype wire

// File: hdl/pattern_encoder.sv
`timescale 1ns/100ps
`default_nettype none

module pattern_encoder (
  input  wire logic               clk,
  input  wire logic               rst_i,
  input  wire logic               advance_i,
  input  wire pixel_pkg::window_t win_i,
  input  wire logic               win_valid_i,
  output lbp_pkg::codes_t         codes_o,
  output logic                    codes_valid_o
);

  import pixel_pkg::*;
  import lbp_pkg::*;

  pixel_t               px [WIN_PIXELS];
  logic [WIN_SUM_W-1:0] win_sum;
  logic [WIN_SUM_W-1:0] nbr_x9 [NUM_NEIGHBORS];
  codes_t               codes_d;

  always_comb begin
    px[0] = win_i.p0;
    px[1] = win_i.p1;
    px[2] = win_i.p2;
    px[3] = win_i.p3;
    px[4] = win_i.p4;
    px[5] = win_i.p5;
    px[6] = win_i.p6;
    px[7] = win_i.p7;
    px[8] = win_i.p8;
  end

  always_comb begin
    win_sum = '0;
    for (int i = 0; i < WIN_PIXELS; i++) begin
      win_sum = win_sum + WIN_SUM_W'(px[i]);
    end
  end

  // Nine times the neighbor, so the mean needs no divider.
  always_comb begin
    for (int k = 0; k < NUM_NEIGHBORS; k++) begin
      nbr_x9[k] = (WIN_SUM_W'(px[NBR_POS[k]]) << 3) + WIN_SUM_W'(px[NBR_POS[k]]);
    end
  end

  always_comb begin
    codes_d = '0;
    for (int k = 0; k < NUM_NEIGHBORS; k++) begin
      codes_d.sign[k] = px[NBR_POS[k]] >= px[CENTER_POS];
      codes_d.ni[k]   = nbr_x9[k] >= win_sum;
    end
  end

  always_ff @(posedge clk) begin
    if (advance_i) begin
      codes_o <= codes_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      codes_valid_o <= 1'b0;
    end else if (advance_i) begin
      codes_valid_o <= win_valid_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/riu2_mapper.sv
`timescale 1ns/100ps
`default_nettype none

module riu2_mapper (
  input  wire logic             clk,
  input  wire logic             rst_i,
  input  wire logic             advance_i,
  input  wire lbp_pkg::codes_t  codes_i,
  input  wire logic             codes_valid_i,
  output lbp_pkg::result_t      res_o,
  output logic                  res_valid_o
);

  import lbp_pkg::*;

  result_t res_d;

  // Popcount for uniform codes, a single bin for all others.
  function automatic label_t riu2_label(code_t code);
    code_t  rot;
    label_t trans;
    label_t ones;
    rot   = {code[0], code[CODE_W-1:1]}; // Circular neighbor of each bit.
    trans = '0;
    ones  = '0;
    for (int i = 0; i < CODE_W; i++) begin
      trans = trans + LABEL_W'(code[i] ^ rot[i]);
      ones  = ones + LABEL_W'(code[i]);
    end
    if (trans <= LABEL_W'(MAX_UNIFORM_TRANS)) begin
      return ones;
    end
    return NONUNIFORM_LABEL;
  endfunction

  always_comb begin
    res_d.sign = riu2_label(codes_i.sign);
    res_d.ni   = riu2_label(codes_i.ni);
  end

  // Held while the consumer stalls.
  always_ff @(posedge clk) begin
    if (advance_i) begin
      res_o <= res_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      res_valid_o <= 1'b0;
    end else if (advance_i) begin
      res_valid_o <= codes_valid_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/lbp_top.sv
`timescale 1ns/100ps
`default_nettype none

module lbp_top (
  input  wire logic              clk,
  input  wire logic              rst_i,
  input  wire logic              pix_valid_i,
  input  wire pixel_pkg::pixel_t pix_i,
  output logic                   pix_ready_o,
  output lbp_pkg::result_t       res_o,
  output logic                   res_valid_o,
  input  wire logic              res_ready_i
);

  import pixel_pkg::*;
  import lbp_pkg::*;

  logic    advance;
  window_t win;
  logic    win_valid;
  codes_t  codes;
  logic    codes_valid;

  // Whole pipe moves together, or freezes when the output is held.
  assign advance     = ~res_valid_o | res_ready_i;
  assign pix_ready_o = advance;

  window_builder u_window_builder (
    .clk         (clk),
    .rst_i       (rst_i),
    .advance_i   (advance),
    .pix_valid_i (pix_valid_i),
    .pix_i       (pix_i),
    .win_o       (win),
    .win_valid_o (win_valid)
  );

  pattern_encoder u_pattern_encoder (
    .clk           (clk),
    .rst_i         (rst_i),
    .advance_i     (advance),
    .win_i         (win),
    .win_valid_i   (win_valid),
    .codes_o       (codes),
    .codes_valid_o (codes_valid)
  );

  // Output register of the design.
  riu2_mapper u_riu2_mapper (
    .clk           (clk),
    .rst_i         (rst_i),
    .advance_i     (advance),
    .codes_i       (codes),
    .codes_valid_i (codes_valid),
    .res_o         (res_o),
    .res_valid_o   (res_valid_o)
  );

endmodule

`default_nettype wire

// File: verification/lbp_model.svh
`ifndef LBP_MODEL_SVH
`define LBP_MODEL_SVH

// Row and column step to each neighbor.
// Bit 0 is east, then counter-clockwise NE, N, NW, W, SW, S, SE.
localparam int ROW_STEP [8] = '{0, -1, -1, -1, 0, 1, 1, 1};
localparam int COL_STEP [8] = '{1, 1, 0, -1, -1, -1, 0, 1};

// Neighbor at least as bright as the center.
function automatic logic [7:0] neighbor_sign_code(input int win [3][3]);
  logic [7:0] code;
  code = '0;
  for (int k = 0; k < 8; k++) begin
    code[k] = win[1 + ROW_STEP[k]][1 + COL_STEP[k]] >= win[1][1];
  end
  return code;
endfunction

// Neighbor at least the window mean, scaled by nine.
function automatic logic [7:0] neighbor_mean_code(input int win [3][3]);
  logic [7:0] code;
  int         total;
  total = 0;
  for (int i = 0; i < 3; i++) begin
    for (int j = 0; j < 3; j++) begin
      total = total + win[i][j];
    end
  end
  code = '0;
  for (int k = 0; k < 8; k++) begin
    code[k] = 9 * win[1 + ROW_STEP[k]][1 + COL_STEP[k]] >= total;
  end
  return code;
endfunction

function automatic logic [3:0] uniform_label(input logic [7:0] code);
  int changes;
  int ones;
  changes = 0;
  ones    = 0;
  for (int k = 0; k < 8; k++) begin
    if (code[k] != code[(k + 1) % 8]) begin
      changes = changes + 1; // Wraps from bit 7 back to bit 0.
    end
    if (code[k]) begin
      ones = ones + 1;
    end
  end
  if (changes > 2) begin
    return 4'd9;
  end
  return ones[3:0];
endfunction

function automatic result_t predict_result(input int win [3][3]);
  result_t r;
  r.sign = uniform_label(neighbor_sign_code(win));
  r.ni   = uniform_label(neighbor_mean_code(win));
  return r;
endfunction

`endif

// File: verification/lbp_tb.sv
`timescale 1ns/100ps
`default_nettype none

module lbp_tb;

  import pixel_pkg::*;
  import lbp_pkg::*;

  `include "lbp_model.svh"

  localparam int FRAME_PIXELS      = IMG_COLS * IMG_ROWS;
  localparam int NUM_FRAMES        = 3;
  localparam int TOTAL_PIXELS      = NUM_FRAMES * FRAME_PIXELS;
  localparam int RESULTS_PER_FRAME = (IMG_COLS - 2) * (IMG_ROWS - 2);
  localparam int TOTAL_RESULTS     = NUM_FRAMES * RESULTS_PER_FRAME;
  localparam int FLAT_FRAME        = 2;
  localparam int RESET_CYCLES      = 8;
  localparam int DRAIN_CYCLES      = 12;
  localparam int TIMEOUT_CYCLES    = TOTAL_PIXELS * 8 + 200;
  localparam logic [31:0] SEED     = 32'h89484885;

  logic    clk;
  logic    rst_i;
  logic    pix_valid_i;
  pixel_t  pix_i;
  logic    pix_ready_o;
  result_t res_o;
  logic    res_valid_o;
  logic    res_ready_i;

  logic [31:0] rng_state;
  int          cycle_count = 0;
  int          sent_count;
  int          out_count;
  int          checks;
  int          value_errors;
  int          other_errors;
  int          nonuniform_seen;
  int          frame_results [NUM_FRAMES];
  pixel_t      frame_img [IMG_ROWS][IMG_COLS];
  pixel_t      flat_value;
  result_t     expect_q [$];
  int          frame_q [$];
  logic        in_xfer;
  logic        out_xfer;
  logic        hold_pending;
  result_t     held_res;

  lbp_top DUT (
    .clk         (clk),
    .rst_i       (rst_i),
    .pix_valid_i (pix_valid_i),
    .pix_i       (pix_i),
    .pix_ready_o (pix_ready_o),
    .res_o       (res_o),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles.", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end else begin
      cycle_count = cycle_count + 1;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_random(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
      value_errors = value_errors + 1;
      $display("** Error: %s = %0h, expected %0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_problem(input string what);
    other_errors = other_errors + 1;
    $display("Error at %0t: %s", $time, what);
  endtask

  // Stores the pixel and queues a result when it closes an interior window.
  task automatic record_input(input pixel_t pix);
    int pos;
    int row;
    int col;
    int win [3][3];
    pos = sent_count % FRAME_PIXELS;
    row = pos / IMG_COLS;
    col = pos % IMG_COLS;
    frame_img[row][col] = pix;
    if (row >= 2 && col >= 2) begin
      for (int i = 0; i < 3; i++) begin
        for (int j = 0; j < 3; j++) begin
          win[i][j] = int'(frame_img[row - 2 + i][col - 2 + j]);
        end
      end
      expect_q.push_back(predict_result(win));
      frame_q.push_back(sent_count / FRAME_PIXELS);
    end
    sent_count = sent_count + 1;
  endtask

  task automatic check_output(input result_t got);
    result_t exp;
    int      fr;
    if (expect_q.size() == 0) begin
      report_problem("a result came out with no expected result pending");
    end else begin
      exp = expect_q.pop_front();
      fr  = frame_q.pop_front();
      frame_results[fr] = frame_results[fr] + 1;
      compare_value("res_o.sign", 32'(got.sign), 32'(exp.sign));
      compare_value("res_o.ni", 32'(got.ni), 32'(exp.ni));
      if (fr == FLAT_FRAME) begin
        compare_value("res_o.sign (flat)", 32'(got.sign), 32'd8); // All ones code.
        compare_value("res_o.ni (flat)", 32'(got.ni), 32'd8);
      end else if (got.sign == 4'd9 || got.ni == 4'd9) begin
        nonuniform_seen = nonuniform_seen + 1;
      end
    end
  endtask

  // Falling edge. A pixel is held until it is taken.
  task automatic drive_inputs();
    logic [31:0] rnd;
    if (in_xfer || !pix_valid_i) begin
      pix_valid_i = 1'b0;
      if (sent_count < TOTAL_PIXELS) begin
        next_random(rnd);
        if (rnd[31:24] < 8'd192) begin
          pix_valid_i = 1'b1;
          next_random(rnd);
          if (sent_count / FRAME_PIXELS == FLAT_FRAME) begin
            pix_i = flat_value;
          end else begin
            pix_i = rnd[23:16];
          end
        end
      end
    end
    next_random(rnd);
    res_ready_i = rnd[31:24] < 8'd179; // About 70 %.
  endtask

  // Called just before the rising edge, when all handshake signals are settled.
  task automatic sample_ports();
    in_xfer  = pix_valid_i && pix_ready_o;
    out_xfer = res_valid_o && res_ready_i;
    // Input is taken whenever the output is free or being read.
    compare_value("pix_ready_o", 32'(pix_ready_o), 32'(!res_valid_o || res_ready_i));
    if (hold_pending) begin
      compare_value("res_valid_o (stalled)", 32'(res_valid_o), 32'd1);
      compare_value("res_o (stalled)", 32'(res_o), 32'(held_res));
    end
    if (in_xfer) begin
      record_input(pix_i);
    end
    if (out_xfer) begin
      out_count = out_count + 1;
      check_output(res_o);
    end
    hold_pending = res_valid_o && !res_ready_i;
    held_res     = res_o;
  endtask

  initial begin
    logic [31:0] rnd;
    clk             = 1'b0;
    rst_i           = 1'b1;
    pix_valid_i     = 1'b0;
    pix_i           = '0;
    res_ready_i     = 1'b0;
    rng_state       = SEED;
    sent_count      = 0;
    out_count       = 0;
    checks          = 0;
    value_errors    = 0;
    other_errors    = 0;
    nonuniform_seen = 0;
    in_xfer         = 1'b0;
    out_xfer        = 1'b0;
    hold_pending    = 1'b0;
    held_res        = '0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      frame_results[f] = 0;
    end
    next_random(rnd);
    flat_value = rnd[15:8];

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    compare_value("res_valid_o after reset", 32'(res_valid_o), 32'd0);

    // Runs until the DUT has handed over as many results as three frames give.
    while (out_count < TOTAL_RESULTS) begin
      drive_inputs();
      #1;
      sample_ports();
      @(negedge clk);
    end

    // Nothing more may come out once the queue is empty.
    pix_valid_i = 1'b0;
    res_ready_i = 1'b1;
    repeat (DRAIN_CYCLES) begin
      @(negedge clk);
      compare_value("res_valid_o (drained)", 32'(res_valid_o), 32'd0);
    end

    for (int f = 0; f < NUM_FRAMES; f++) begin
      if (frame_results[f] != RESULTS_PER_FRAME) begin
        report_problem($sformatf("frame %0d gave %0d results instead of %0d",
                                 f, frame_results[f], RESULTS_PER_FRAME));
      end
    end
    if (expect_q.size() != 0) begin
      report_problem("expected results were left over at the end of the run");
    end
    if (nonuniform_seen == 0) begin
      report_problem("no non-uniform label 9 was seen on the random frames");
    end

    $display("Checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verification
hdl/pixel_pkg.sv
hdl/lbp_pkg.sv
hdl/window_builder.sv
hdl/pattern_encoder.sv
hdl/riu2_mapper.sv
hdl/lbp_top.sv
verification/lbp_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log for a failure.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps \
  -f sim.f --top-module lbp_tb -Mdir obj_dir -o lbp_sim

./obj_dir/lbp_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported a failure, see sim.log."
  exit 1
fi

echo "Simulation passed."
